// ==== design/cpuPkg.sv ====
package cpuPkg;

  // Datapath and addressing
  localparam int dataBits = 32;
  localparam logic [dataBits-1:0] instBytes = 32'd4;
  localparam logic [dataBits-1:0] startPc = 32'h0000_0100;
  localparam int regNoBits = 4;
  localparam int immBits = 16;

  // Both memories are indexed by address bits 15:2
  localparam int imemWordBits = 14;
  localparam int dmemWordBits = 14;

  localparam int op1Bits = 6;
  localparam int fnBits = 8;

  // Primary opcodes
  localparam logic [op1Bits-1:0] opAlur = 6'b000000;
  localparam logic [op1Bits-1:0] opBeq = 6'b001000;
  localparam logic [op1Bits-1:0] opBlt = 6'b001001;
  localparam logic [op1Bits-1:0] opBle = 6'b001010;
  localparam logic [op1Bits-1:0] opBne = 6'b001011;
  localparam logic [op1Bits-1:0] opJal = 6'b001100;
  localparam logic [op1Bits-1:0] opLw = 6'b010010;
  localparam logic [op1Bits-1:0] opSw = 6'b011010;
  localparam logic [op1Bits-1:0] opAddi = 6'b100000;
  localparam logic [op1Bits-1:0] opAndi = 6'b100100;
  localparam logic [op1Bits-1:0] opOri = 6'b100101;
  localparam logic [op1Bits-1:0] opXori = 6'b100110;

  // Secondary opcodes for the register form
  localparam logic [fnBits-1:0] fnEq = 8'b00001000;
  localparam logic [fnBits-1:0] fnLt = 8'b00001001;
  localparam logic [fnBits-1:0] fnLe = 8'b00001010;
  localparam logic [fnBits-1:0] fnNe = 8'b00001011;
  localparam logic [fnBits-1:0] fnAdd = 8'b00100000;
  localparam logic [fnBits-1:0] fnAnd = 8'b00100100;
  localparam logic [fnBits-1:0] fnOr = 8'b00100101;
  localparam logic [fnBits-1:0] fnXor = 8'b00100110;
  localparam logic [fnBits-1:0] fnSub = 8'b00101000;
  localparam logic [fnBits-1:0] fnNand = 8'b00101100;
  localparam logic [fnBits-1:0] fnNor = 8'b00101101;
  localparam logic [fnBits-1:0] fnNxor = 8'b00101110;
  localparam logic [fnBits-1:0] fnRshf = 8'b00110000;
  localparam logic [fnBits-1:0] fnLshf = 8'b00110001;

  // Register form ALU op with r0 operands, so it changes nothing
  localparam logic [dataBits-1:0] nopWord = '0;

  // Memory-mapped I/O
  localparam int hexBits = 24;
  localparam int ledBits = 10;
  localparam int keyBits = 4;
  localparam logic [dataBits-1:0] addrHex = 32'hFFFF_F000;
  localparam logic [dataBits-1:0] addrLedr = 32'hFFFF_F020;
  localparam logic [dataBits-1:0] addrKey = 32'hFFFF_F080;
  localparam logic [hexBits-1:0] hexResetValue = 24'hFEDEAD;

  // One instruction word seen as register form or immediate form
  typedef union packed {
    struct packed {
      logic [op1Bits-1:0] op1;
      logic [fnBits-1:0] fn;
      logic [5:0] unused;
      logic [regNoBits-1:0] rd;
      logic [regNoBits-1:0] rs;
      logic [regNoBits-1:0] rt;
    } r;
    struct packed {
      logic [op1Bits-1:0] op1;
      logic [1:0] unused;
      logic [immBits-1:0] imm;
      logic [regNoBits-1:0] rs;
      logic [regNoBits-1:0] rt;
    } i;
  } instWord;

endpackage

// ==== design/fetchStage.sv ====
`timescale 1ns/100ps

module fetchStage (
  input  logic clk,
  input  logic reset,
  input  logic run,
  input  logic loadValid,
  input  logic [cpuPkg::imemWordBits-1:0] loadAddr,
  input  logic [cpuPkg::dataBits-1:0] loadData,
  output logic loadReady,
  input  logic stall,
  input  logic redirect,
  input  logic [cpuPkg::dataBits-1:0] redirectPc,
  output cpuPkg::instWord fetchInst,
  output logic [cpuPkg::dataBits-1:0] fetchPc
);
  import cpuPkg::*;

  logic [dataBits-1:0] imem [0:(1 << imemWordBits)-1];
  logic [dataBits-1:0] pc;
  logic [dataBits-1:0] memWord;

  // Program can only be written while the core is idle
  assign loadReady = !run;

  always_ff @(posedge clk) begin
    if (loadValid && loadReady) begin
      imem[loadAddr] <= loadData;
    end
  end

  assign memWord = imem[pc[imemWordBits+1:2]];

  // PC update, redirect beats stall
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pc <= startPc;
    end else if (!run) begin
      pc <= startPc;
    end else if (redirect) begin
      pc <= redirectPc;
    end else if (!stall) begin
      pc <= pc + instBytes;
    end
  end

  // Fetch latch
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      fetchInst <= nopWord;
      fetchPc <= startPc;
    end else if (!run || redirect) begin
      // Wrong-path or idle slot
      fetchInst <= nopWord;
      fetchPc <= startPc;
    end else if (!stall) begin
      fetchInst <= memWord;
      fetchPc <= pc;
    end
  end

  // Loading must be finished before the core runs
  assert property (@(posedge clk) disable iff (reset) run |-> !loadValid)
    else $error("load request while the core is running");

endmodule

// ==== design/decodeStage.sv ====
`timescale 1ns/100ps

module decodeStage (
  input  logic clk,
  input  logic reset,
  input  logic run,
  input  cpuPkg::instWord fetchInst,
  input  logic [cpuPkg::dataBits-1:0] fetchPc,
  output logic stall,
  input  logic wbEnable,
  input  logic [cpuPkg::regNoBits-1:0] wbReg,
  input  logic [cpuPkg::dataBits-1:0] wbData,
  input  logic redirect,
  output logic [cpuPkg::op1Bits-1:0] op1,
  output logic [cpuPkg::fnBits-1:0] fn,
  output logic [cpuPkg::dataBits-1:0] rs1Value,
  output logic [cpuPkg::dataBits-1:0] rs2Value,
  output logic [cpuPkg::dataBits-1:0] immValue,
  output logic [cpuPkg::dataBits-1:0] instPc,
  output logic [cpuPkg::regNoBits-1:0] destReg,
  output logic isBranch,
  output logic isJump,
  output logic memRead,
  output logic memWrite,
  output logic regWrite
);
  import cpuPkg::*;

  logic [dataBits-1:0] regs [0:(1 << regNoBits)-1];
  logic [op1Bits-1:0] opNow;
  logic [regNoBits-1:0] rsNow;
  logic [regNoBits-1:0] rtNow;
  logic [regNoBits-1:0] destNow;
  logic [regNoBits-1:0] exDest;
  logic aluRegNow;
  logic immAluNow;
  logic branchNow;
  logic jumpNow;
  logic loadNow;
  logic storeNow;
  logic readsRs;
  logic readsRt;
  logic rsBusy;
  logic rtBusy;
  logic bubble;
  logic [dataBits-1:0] rsValue;
  logic [dataBits-1:0] rtValue;
  logic [dataBits-1:0] immExt;

  assign opNow = fetchInst.r.op1;
  assign rsNow = fetchInst.r.rs;
  assign rtNow = fetchInst.r.rt;
  assign immExt = {{(dataBits-immBits){fetchInst.i.imm[immBits-1]}}, fetchInst.i.imm};

  assign aluRegNow = opNow == opAlur;
  assign immAluNow = opNow inside {opAddi, opAndi, opOri, opXori};
  assign branchNow = opNow inside {opBeq, opBlt, opBle, opBne};
  assign jumpNow = opNow == opJal;
  assign loadNow = opNow == opLw;
  assign storeNow = opNow == opSw;

  // Register form writes rd, immediate forms and JAL write rt
  always_comb begin
    if (aluRegNow) begin
      destNow = fetchInst.r.rd;
    end else if (immAluNow || loadNow || jumpNow) begin
      destNow = rtNow;
    end else begin
      destNow = '0;
    end
  end

  assign readsRs = aluRegNow || immAluNow || branchNow || jumpNow || loadNow || storeNow;
  assign readsRt = aluRegNow || branchNow || storeNow;

  // Source still owned by an instruction in execute, memory or writeback
  assign rsBusy = readsRs && (rsNow != '0) &&
      (rsNow == destReg || rsNow == exDest || (wbEnable && rsNow == wbReg));
  assign rtBusy = readsRt && (rtNow != '0) &&
      (rtNow == destReg || rtNow == exDest || (wbEnable && rtNow == wbReg));
  assign stall = rsBusy || rtBusy;

  // r0 always reads as zero
  assign rsValue = (rsNow == '0) ? '0 : regs[rsNow];
  assign rtValue = (rtNow == '0) ? '0 : regs[rtNow];

  always_ff @(posedge clk) begin
    if (wbEnable && wbReg != '0) begin
      regs[wbReg] <= wbData;
    end
  end

  assign bubble = !run || stall || redirect;

  // Decode latch, control part
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      op1 <= opAlur;
      fn <= '0;
      destReg <= '0;
      exDest <= '0;
      isBranch <= 1'b0;
      isJump <= 1'b0;
      memRead <= 1'b0;
      memWrite <= 1'b0;
      regWrite <= 1'b0;
    end else begin
      // Execute latches its destination every cycle, so track it here
      exDest <= destReg;
      if (bubble) begin
        op1 <= opAlur;
        fn <= '0;
        destReg <= '0;
        isBranch <= 1'b0;
        isJump <= 1'b0;
        memRead <= 1'b0;
        memWrite <= 1'b0;
        regWrite <= 1'b0;
      end else begin
        op1 <= opNow;
        fn <= fetchInst.r.fn;
        destReg <= destNow;
        isBranch <= branchNow;
        isJump <= jumpNow;
        memRead <= loadNow;
        memWrite <= storeNow;
        regWrite <= destNow != '0;
      end
    end
  end

  // Operands and address
  always_ff @(posedge clk) begin
    rs1Value <= rsValue;
    rs2Value <= rtValue;
    immValue <= immExt;
    instPc <= fetchPc;
  end

  assert property (@(posedge clk) disable iff (reset) !regWrite |-> destReg == '0)
    else $error("destination set without register write");

endmodule

// ==== design/executeStage.sv ====
`timescale 1ns/100ps

module executeStage (
  input  logic clk,
  input  logic reset,
  input  logic [cpuPkg::op1Bits-1:0] op1,
  input  logic [cpuPkg::fnBits-1:0] fn,
  input  logic [cpuPkg::dataBits-1:0] rs1Value,
  input  logic [cpuPkg::dataBits-1:0] rs2Value,
  input  logic [cpuPkg::dataBits-1:0] immValue,
  input  logic [cpuPkg::dataBits-1:0] instPc,
  input  logic [cpuPkg::regNoBits-1:0] destReg,
  input  logic isBranch,
  input  logic isJump,
  input  logic memRead,
  input  logic memWrite,
  input  logic regWrite,
  output logic redirect,
  output logic [cpuPkg::dataBits-1:0] redirectPc,
  output logic [cpuPkg::dataBits-1:0] aluResult,
  output logic [cpuPkg::dataBits-1:0] storeData,
  output logic [cpuPkg::regNoBits-1:0] exDestReg,
  output logic exMemRead,
  output logic exMemWrite,
  output logic exRegWrite
);
  import cpuPkg::*;

  logic taken;
  logic [dataBits-1:0] retAddr;
  logic [dataBits-1:0] immWords;
  logic [dataBits-1:0] aluNow;

  // Signed compares for branches
  always_comb begin
    case (op1)
      opBeq: taken = rs1Value == rs2Value;
      opBlt: taken = $signed(rs1Value) < $signed(rs2Value);
      opBle: taken = $signed(rs1Value) <= $signed(rs2Value);
      opBne: taken = rs1Value != rs2Value;
      default: taken = 1'b0;
    endcase
  end

  assign retAddr = instPc + instBytes;
  assign immWords = immValue << 2;

  assign redirect = (isBranch && taken) || isJump;
  // JAL is register relative, branches are PC relative
  assign redirectPc = isJump ? rs1Value + immWords : retAddr + immWords;

  always_comb begin
    case (op1)
      opAlur: begin
        case (fn)
          fnEq: aluNow = {{(dataBits-1){1'b0}}, rs1Value == rs2Value};
          fnLt: aluNow = {{(dataBits-1){1'b0}}, $signed(rs1Value) < $signed(rs2Value)};
          fnLe: aluNow = {{(dataBits-1){1'b0}}, $signed(rs1Value) <= $signed(rs2Value)};
          fnNe: aluNow = {{(dataBits-1){1'b0}}, rs1Value != rs2Value};
          fnAdd: aluNow = rs1Value + rs2Value;
          fnAnd: aluNow = rs1Value & rs2Value;
          fnOr: aluNow = rs1Value | rs2Value;
          fnXor: aluNow = rs1Value ^ rs2Value;
          fnSub: aluNow = rs1Value - rs2Value;
          fnNand: aluNow = ~(rs1Value & rs2Value);
          fnNor: aluNow = ~(rs1Value | rs2Value);
          fnNxor: aluNow = ~(rs1Value ^ rs2Value);
          // Whole rt value is the shift amount
          fnRshf: aluNow = $signed(rs1Value) >>> rs2Value;
          fnLshf: aluNow = rs1Value << rs2Value;
          default: aluNow = '0;
        endcase
      end
      opLw, opSw, opAddi: aluNow = rs1Value + immValue;
      opAndi: aluNow = rs1Value & immValue;
      opOri: aluNow = rs1Value | immValue;
      opXori: aluNow = rs1Value ^ immValue;
      opJal: aluNow = retAddr;
      default: aluNow = '0;
    endcase
  end

  // Execute latch, control part
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      exDestReg <= '0;
      exMemRead <= 1'b0;
      exMemWrite <= 1'b0;
      exRegWrite <= 1'b0;
    end else begin
      exDestReg <= destReg;
      exMemRead <= memRead;
      exMemWrite <= memWrite;
      exRegWrite <= regWrite;
    end
  end

  always_ff @(posedge clk) begin
    aluResult <= aluNow;
    storeData <= rs2Value;
  end

  // The younger instruction behind a redirect must already be squashed by decode
  assert property (@(posedge clk) disable iff (reset)
      redirect |-> (isBranch || isJump) ##1 !(isBranch || isJump || regWrite || memWrite))
    else $error("redirect without flush of the younger instruction");

endmodule

// ==== design/memoryStage.sv ====
`timescale 1ns/100ps

module memoryStage (
  input  logic clk,
  input  logic reset,
  input  logic [cpuPkg::dataBits-1:0] aluResult,
  input  logic [cpuPkg::dataBits-1:0] storeData,
  input  logic [cpuPkg::regNoBits-1:0] exDestReg,
  input  logic exMemRead,
  input  logic exMemWrite,
  input  logic exRegWrite,
  input  logic [cpuPkg::keyBits-1:0] key,
  output logic wbEnable,
  output logic [cpuPkg::regNoBits-1:0] wbReg,
  output logic [cpuPkg::dataBits-1:0] wbData,
  output logic [cpuPkg::hexBits-1:0] hexValue,
  output logic [cpuPkg::ledBits-1:0] ledValue
);
  import cpuPkg::*;

  logic [dataBits-1:0] dmem [0:(1 << dmemWordBits)-1];
  logic [dmemWordBits-1:0] wordIdx;
  logic isHex;
  logic isLed;
  logic isKey;
  logic [dataBits-1:0] loadValue;

  assign wordIdx = aluResult[dmemWordBits+1:2];
  assign isHex = aluResult == addrHex;
  assign isLed = aluResult == addrLedr;
  assign isKey = aluResult == addrKey;

  // Keys are active low on the board
  assign loadValue = isKey ? {{(dataBits-keyBits){1'b0}}, ~key} : dmem[wordIdx];

  always_ff @(posedge clk) begin
    if (exMemWrite && !(isHex || isLed || isKey)) begin
      dmem[wordIdx] <= storeData;
    end
  end

  // I/O registers
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      hexValue <= hexResetValue;
      ledValue <= '0;
    end else if (exMemWrite) begin
      if (isHex) begin
        hexValue <= storeData[hexBits-1:0];
      end
      if (isLed) begin
        ledValue <= storeData[ledBits-1:0];
      end
    end
  end

  // Writeback latch
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wbEnable <= 1'b0;
      wbReg <= '0;
    end else begin
      wbEnable <= exRegWrite;
      wbReg <= exDestReg;
    end
  end

  always_ff @(posedge clk) begin
    wbData <= exMemRead ? loadValue : aluResult;
  end

  assert property (@(posedge clk) disable iff (reset)
      (exMemRead || exMemWrite) |-> aluResult[1:0] == 2'b00)
    else $error("unaligned data access at %h", aluResult);

endmodule

// ==== design/cpuTop.sv ====
`timescale 1ns/100ps

module cpuTop (
  input  logic clk,
  input  logic reset,
  input  logic run,
  input  logic loadValid,
  output logic loadReady,
  input  logic [cpuPkg::imemWordBits-1:0] loadAddr,
  input  logic [cpuPkg::dataBits-1:0] loadData,
  input  logic [cpuPkg::keyBits-1:0] key,
  output logic [cpuPkg::hexBits-1:0] hexValue,
  output logic [cpuPkg::ledBits-1:0] ledValue
);
  import cpuPkg::*;

  // Fetch to decode
  instWord fetchInst;
  logic [dataBits-1:0] fetchPc;
  logic stall;

  // Decode to execute
  logic [op1Bits-1:0] op1;
  logic [fnBits-1:0] fn;
  logic [dataBits-1:0] rs1Value;
  logic [dataBits-1:0] rs2Value;
  logic [dataBits-1:0] immValue;
  logic [dataBits-1:0] instPc;
  logic [regNoBits-1:0] destReg;
  logic isBranch;
  logic isJump;
  logic memRead;
  logic memWrite;
  logic regWrite;

  // Execute to memory and fetch
  logic redirect;
  logic [dataBits-1:0] redirectPc;
  logic [dataBits-1:0] aluResult;
  logic [dataBits-1:0] storeData;
  logic [regNoBits-1:0] exDestReg;
  logic exMemRead;
  logic exMemWrite;
  logic exRegWrite;

  // Register file write back into decode
  logic wbEnable;
  logic [regNoBits-1:0] wbReg;
  logic [dataBits-1:0] wbData;

  fetchStage fetch (
    .clk(clk),
    .reset(reset),
    .run(run),
    .loadValid(loadValid),
    .loadAddr(loadAddr),
    .loadData(loadData),
    .loadReady(loadReady),
    .stall(stall),
    .redirect(redirect),
    .redirectPc(redirectPc),
    .fetchInst(fetchInst),
    .fetchPc(fetchPc)
  );

  decodeStage decode (
    .clk(clk),
    .reset(reset),
    .run(run),
    .fetchInst(fetchInst),
    .fetchPc(fetchPc),
    .stall(stall),
    .wbEnable(wbEnable),
    .wbReg(wbReg),
    .wbData(wbData),
    .redirect(redirect),
    .op1(op1),
    .fn(fn),
    .rs1Value(rs1Value),
    .rs2Value(rs2Value),
    .immValue(immValue),
    .instPc(instPc),
    .destReg(destReg),
    .isBranch(isBranch),
    .isJump(isJump),
    .memRead(memRead),
    .memWrite(memWrite),
    .regWrite(regWrite)
  );

  executeStage execute (
    .clk(clk),
    .reset(reset),
    .op1(op1),
    .fn(fn),
    .rs1Value(rs1Value),
    .rs2Value(rs2Value),
    .immValue(immValue),
    .instPc(instPc),
    .destReg(destReg),
    .isBranch(isBranch),
    .isJump(isJump),
    .memRead(memRead),
    .memWrite(memWrite),
    .regWrite(regWrite),
    .redirect(redirect),
    .redirectPc(redirectPc),
    .aluResult(aluResult),
    .storeData(storeData),
    .exDestReg(exDestReg),
    .exMemRead(exMemRead),
    .exMemWrite(exMemWrite),
    .exRegWrite(exRegWrite)
  );

  memoryStage memory (
    .clk(clk),
    .reset(reset),
    .aluResult(aluResult),
    .storeData(storeData),
    .exDestReg(exDestReg),
    .exMemRead(exMemRead),
    .exMemWrite(exMemWrite),
    .exRegWrite(exRegWrite),
    .key(key),
    .wbEnable(wbEnable),
    .wbReg(wbReg),
    .wbData(wbData),
    .hexValue(hexValue),
    .ledValue(ledValue)
  );

endmodule

// ==== bench/cpuBench.sv ====
`timescale 1ns/100ps

module cpuBench;
  import cpuPkg::*;

  localparam int clkPeriod = 8;
  // One program run covers loading, execution and draining
  localparam int runBudget = 180;
  localparam int runTotal = 41;
  localparam int waitLimit = 120;
  localparam logic [imemWordBits-1:0] progBase = startPc[imemWordBits+1:2];

  logic clk;
  logic reset;
  logic run;
  logic loadValid;
  logic loadReady;
  logic [imemWordBits-1:0] loadAddr;
  logic [dataBits-1:0] loadData;
  logic [keyBits-1:0] key;
  logic [hexBits-1:0] hexValue;
  logic [ledBits-1:0] ledValue;

  integer seed;
  int errorCount;
  int checkCount;
  int markerSeq;
  logic [31:0] prog [$];

  cpuTop DUT (
    .clk(clk),
    .reset(reset),
    .run(run),
    .loadValid(loadValid),
    .loadReady(loadReady),
    .loadAddr(loadAddr),
    .loadData(loadData),
    .key(key),
    .hexValue(hexValue),
    .ledValue(ledValue)
  );

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  initial begin
    #(runTotal * runBudget * clkPeriod);
    $display("Watchdog expired after %0d cycles, the simulation is stuck", runTotal * runBudget);
    $display("test failed");
    $finish;
  end

  function automatic logic [31:0] sext16(input logic [15:0] v);
    return {{16{v[15]}}, v};
  endfunction

  function automatic logic [31:0] regInst(input logic [7:0] fnCode, input logic [3:0] rd,
      input logic [3:0] rs, input logic [3:0] rt);
    return {opAlur, fnCode, 6'b000000, rd, rs, rt};
  endfunction

  function automatic logic [31:0] immInst(input logic [5:0] op, input logic [15:0] imm,
      input logic [3:0] rs, input logic [3:0] rt);
    return {op, 2'b00, imm, rs, rt};
  endfunction

  // Expected results of the register-form operations
  function automatic logic [31:0] aluModel(input logic [7:0] fnCode, input logic [31:0] a,
      input logic [31:0] b);
    case (fnCode)
      fnEq: return {31'b0, a == b};
      fnLt: return {31'b0, $signed(a) < $signed(b)};
      fnLe: return {31'b0, $signed(a) <= $signed(b)};
      fnNe: return {31'b0, a != b};
      fnAdd: return a + b;
      fnAnd: return a & b;
      fnOr: return a | b;
      fnXor: return a ^ b;
      fnSub: return a - b;
      fnNand: return ~(a & b);
      fnNor: return ~(a | b);
      fnNxor: return ~(a ^ b);
      fnRshf: return $signed(a) >>> b;
      fnLshf: return a << b;
      default: return 32'h0;
    endcase
  endfunction

  task automatic checkValue(input string name, input logic [31:0] expected,
      input logic [31:0] actual);
    checkCount++;
    assert (actual === expected) else begin
      $display("ERROR %s: expected %h, actual %h", name, expected, actual);
      errorCount++;
    end
  endtask

  task automatic checkHex(input string name, input logic [31:0] expected);
    checkValue(name, {8'h00, expected[hexBits-1:0]}, {8'h00, hexValue});
  endtask

  task automatic beginProgram();
    prog.delete();
    // r15 is the I/O base, hex at +0, LEDs at +20, keys at +80
    prog.push_back(immInst(opAddi, 16'hF000, 4'd0, 4'd15));
  endtask

  // Full 32-bit constant, upper half corrected for the sign of the lower half
  task automatic loadConst(input logic [3:0] r, input logic [31:0] v);
    logic [15:0] hi;
    hi = v[31:16] + {15'b0, v[15]};
    prog.push_back(immInst(opAddi, hi, 4'd0, r));
    prog.push_back(immInst(opAddi, 16'd16, 4'd0, 4'd13));
    prog.push_back(regInst(fnLshf, r, r, 4'd13));
    prog.push_back(immInst(opAddi, v[15:0], r, r));
  endtask

  task automatic storeHex(input logic [3:0] r);
    prog.push_back(immInst(opSw, 16'h0000, 4'd15, r));
  endtask

  task automatic storeLed(input logic [3:0] r);
    prog.push_back(immInst(opSw, 16'h0020, 4'd15, r));
  endtask

  task automatic endProgram(output logic [ledBits-1:0] marker);
    markerSeq++;
    marker = ledBits'(markerSeq);
    prog.push_back(immInst(opAddi, 16'(markerSeq), 4'd0, 4'd12));
    storeLed(4'd12);
  endtask

  // Load through the handshake, run until the LEDs show doneValue, then idle again
  task automatic runProgram(input string name, input logic [ledBits-1:0] doneValue);
    int cycles;
    // Branch to itself keeps the core parked after the program
    prog.push_back(immInst(opBeq, 16'hFFFF, 4'd0, 4'd0));
    prog.push_back(nopWord);
    prog.push_back(nopWord);
    @(negedge clk);
    checkValue({name, " loadReady idle"}, 32'd1, {31'b0, loadReady});
    @(posedge clk);
    #1;
    foreach (prog[i]) begin
      loadValid = 1'b1;
      loadAddr = progBase + imemWordBits'(i);
      loadData = prog[i];
      @(posedge clk);
      while (!loadReady) begin
        @(posedge clk);
      end
      #1;
    end
    loadValid = 1'b0;
    run = 1'b1;
    @(negedge clk);
    checkValue({name, " loadReady running"}, 32'd0, {31'b0, loadReady});
    cycles = 0;
    while (ledValue !== doneValue && cycles < waitLimit) begin
      @(negedge clk);
      cycles++;
    end
    if (ledValue !== doneValue) begin
      $display("%s: the program did not show %h on the LEDs within %0d cycles",
          name, doneValue, waitLimit);
      errorCount++;
    end
    @(posedge clk);
    #1;
    run = 1'b0;
    repeat (4) @(posedge clk);
  endtask

  task automatic testResetValues();
    @(negedge clk);
    checkValue("reset hex", {8'h00, hexResetValue}, {8'h00, hexValue});
    checkValue("reset leds", 32'd0, {22'b0, ledValue});
  endtask

  task automatic testHandshake();
    logic [ledBits-1:0] marker;
    beginProgram();
    prog.push_back(immInst(opAddi, 16'h05A5, 4'd0, 4'd3));
    storeHex(4'd3);
    endProgram(marker);
    runProgram("handshake", marker);
    checkHex("handshake", 32'h0000_05A5);
  endtask

  task automatic testAluOps();
    logic [7:0] fnList [0:13];
    logic [31:0] a;
    logic [31:0] b;
    logic [ledBits-1:0] marker;
    string name;
    fnList = '{fnEq, fnLt, fnLe, fnNe, fnAdd, fnAnd, fnOr, fnXor, fnSub, fnNand, fnNor,
        fnNxor, fnRshf, fnLshf};
    for (int pass = 0; pass < 2; pass++) begin
      foreach (fnList[k]) begin
        a = $random(seed);
        // Second pass uses equal operands for the compares
        b = (pass == 1) ? a : $random(seed);
        if (fnList[k] == fnRshf || fnList[k] == fnLshf) begin
          b = b & 32'd31;
        end
        name = $sformatf("alu fn %02h pass %0d", fnList[k], pass);
        beginProgram();
        loadConst(4'd1, a);
        loadConst(4'd2, b);
        prog.push_back(regInst(fnList[k], 4'd3, 4'd1, 4'd2));
        storeHex(4'd3);
        endProgram(marker);
        runProgram(name, marker);
        checkHex(name, aluModel(fnList[k], a, b));
      end
    end
  endtask

  // Each instruction needs the result of the one right before it
  task automatic testDependentImm();
    logic [ledBits-1:0] marker;
    logic [31:0] expected;
    beginProgram();
    prog.push_back(immInst(opAddi, 16'hFFFB, 4'd0, 4'd1));
    prog.push_back(immInst(opAddi, 16'hFED4, 4'd1, 4'd2));
    prog.push_back(immInst(opXori, 16'h8001, 4'd2, 4'd3));
    prog.push_back(immInst(opAndi, 16'hFFF0, 4'd3, 4'd4));
    prog.push_back(immInst(opOri, 16'h8000, 4'd4, 4'd5));
    prog.push_back(immInst(opAddi, 16'hFB2E, 4'd5, 4'd6));
    storeHex(4'd6);
    endProgram(marker);
    expected = sext16(16'hFFFB) + sext16(16'hFED4);
    expected = expected ^ sext16(16'h8001);
    expected = expected & sext16(16'hFFF0);
    expected = expected | sext16(16'h8000);
    expected = expected + sext16(16'hFB2E);
    runProgram("dependent imm", marker);
    checkHex("dependent imm", expected);
  endtask

  task automatic testStoreLoad();
    logic [31:0] v;
    v = $random(seed);
    // Bit 9 set keeps the LED value apart from every done marker
    v[9] = 1'b1;
    beginProgram();
    loadConst(4'd1, v);
    prog.push_back(immInst(opAddi, 16'h0240, 4'd0, 4'd2));
    prog.push_back(immInst(opSw, 16'h0008, 4'd2, 4'd1));
    prog.push_back(immInst(opSw, 16'h000C, 4'd2, 4'd0));
    prog.push_back(immInst(opLw, 16'h0008, 4'd2, 4'd3));
    storeHex(4'd3);
    storeLed(4'd3);
    runProgram("store load", v[ledBits-1:0]);
    checkValue("store load leds", {22'b0, v[ledBits-1:0]}, {22'b0, ledValue});
    checkHex("store load hex", v);
  endtask

  task automatic branchCase(input string name, input logic [5:0] op, input int a,
      input int b);
    logic [ledBits-1:0] marker;
    logic [15:0] goodValue;
    bit taken;
    case (op)
      opBeq: taken = a == b;
      opBlt: taken = a < b;
      opBle: taken = a <= b;
      default: taken = a != b;
    endcase
    goodValue = 16'h0600 + 16'(markerSeq);
    beginProgram();
    prog.push_back(immInst(opAddi, 16'(a), 4'd0, 4'd1));
    prog.push_back(immInst(opAddi, 16'(b), 4'd0, 4'd2));
    prog.push_back(immInst(opAddi, goodValue, 4'd0, 4'd5));
    prog.push_back(immInst(opAddi, 16'h7BAD, 4'd0, 4'd7));
    storeHex(4'd5);
    // Skips the two shadow stores when taken
    prog.push_back(immInst(op, 16'd2, 4'd1, 4'd2));
    storeHex(4'd7);
    storeHex(4'd7);
    endProgram(marker);
    runProgram(name, marker);
    checkHex(name, taken ? {16'h0000, goodValue} : 32'h0000_7BAD);
  endtask

  task automatic testBranches();
    branchCase("beq taken", opBeq, 3, 3);
    branchCase("beq not taken", opBeq, 3, 4);
    branchCase("blt taken", opBlt, -2, 5);
    branchCase("blt not taken", opBlt, 5, -2);
    branchCase("ble taken", opBle, 4, 4);
    branchCase("ble not taken", opBle, 5, 4);
    branchCase("bne taken", opBne, 1, 2);
    branchCase("bne not taken", opBne, 7, 7);
  endtask

  task automatic testJal();
    logic [ledBits-1:0] marker;
    beginProgram();
    prog.push_back(immInst(opAddi, 16'h0100, 4'd0, 4'd8));
    prog.push_back(immInst(opAddi, 16'h0111, 4'd0, 4'd9));
    // At word 3, jumps to r8 + 24, which is word 6
    prog.push_back(immInst(opJal, 16'd6, 4'd8, 4'd9));
    prog.push_back(immInst(opAddi, 16'h7BAD, 4'd0, 4'd9));
    prog.push_back(immInst(opAddi, 16'h7BAD, 4'd0, 4'd9));
    storeHex(4'd9);
    endProgram(marker);
    runProgram("jal", marker);
    checkHex("jal", startPc + instBytes * 3 + instBytes);
  endtask

  task automatic testKeyRead();
    logic [ledBits-1:0] marker;
    @(posedge clk);
    #1;
    key = 4'($random(seed));
    beginProgram();
    prog.push_back(immInst(opLw, 16'h0080, 4'd15, 4'd3));
    storeHex(4'd3);
    endProgram(marker);
    runProgram("key read", marker);
    checkHex("key read", {28'h0000000, ~key});
  endtask

  initial begin
    seed = 58450;
    errorCount = 0;
    checkCount = 0;
    markerSeq = 0;
    reset = 1'b1;
    run = 1'b0;
    loadValid = 1'b0;
    loadAddr = '0;
    loadData = '0;
    key = '0;
    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;
    testResetValues();
    testHandshake();
    testAluOps();
    testDependentImm();
    testStoreLoad();
    testBranches();
    testJal();
    testKeyRead();
    $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
design/cpuPkg.sv
design/fetchStage.sv
design/decodeStage.sv
design/executeStage.sv
design/memoryStage.sv
design/cpuTop.sv
bench/cpuBench.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the processor testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f sim.f \
  --top-module cpuBench -Mdir obj_dir -o cpuSim > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
  cat build.log
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/cpuSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "test failed" sim.log; then
  exit 1
fi
if ! grep -q "test passed" sim.log; then
  echo "Simulation ended without a result line"
  exit 1
fi
exit 0
